// File: verilog.f
+incdir+include
design/dcache_pkg.sv
design/dcache_rr_arbiter.sv
design/dcache_bank_ctrl.sv
design/dcache_data_bank.sv
design/dcache_tag_array.sv
design/dcache_hit_select.sv
design/dcache_mem_top.sv
dv/dcache_mem_chk.sv
dv/dcache_mem_tb.sv

// File: dv/dcache_mem_tb.sv
////////////////////
// testbench for the cache memories with random stimulus, reference model and checks
////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_mem_tb;
    import dcache_pkg::*;

    localparam int unsigned NP = `DCACHE_NUM_PORTS;
    localparam int unsigned NW = `DCACHE_WAYS;
    localparam int unsigned INIT_CYCLES = NW * `DCACHE_NUM_SETS;
    localparam int unsigned PHASE_CYCLES = 400;
    localparam int unsigned TOTAL_CYCLES = 4 + INIT_CYCLES + 4 * PHASE_CYCLES;
    localparam int unsigned CYCLE_LIMIT = 4 * TOTAL_CYCLES;
    localparam int unsigned WORD_BYTES = `DCACHE_WORD_W / 8;

    logic clk_i;
    logic rst_ni;
    port_vec_t rd_req_i, rd_tag_only_i, rd_prio_i, rd_ack_o;
    idx_t [NP-1:0] rd_idx_i;
    off_t [NP-1:0] rd_off_i;
    tag_t [NP-1:0] rd_tag_i;
    way_vec_t rd_vld_bits_o, rd_hit_oh_o;
    word_t rd_data_o;
    logic wr_cl_vld_i;
    way_vec_t wr_cl_we_i, wr_vld_bits_i, wr_req_i;
    tag_t wr_cl_tag_i;
    idx_t wr_cl_idx_i, wr_idx_i;
    line_t wr_cl_data_i;
    line_be_t wr_cl_data_be_i;
    logic wr_ack_o;
    off_t wr_off_i;
    word_t wr_data_i;
    word_be_t wr_data_be_i;

    // reference model of the arrays and the arbiter pointer
    tag_t m_tag [NW][`DCACHE_NUM_SETS];
    logic m_vld [NW][`DCACHE_NUM_SETS];
    word_t m_data [NW][`DCACHE_NUM_SETS][`DCACHE_NUM_BANKS];
    port_idx_t m_ptr;

    logic [31:0] lcg_state;
    string test_name;
    int unsigned err_cnt [3];
    int unsigned cycle_cnt = 0;
    int unsigned p_read, p_refill, p_write, p_tag_only, p_miss;
    tag_t want_tag [NP];
    port_vec_t acked;
    logic wr_done;
    // lookup in flight with its results due one cycle after its ack
    logic pend_vld, pend_data_chk;
    port_idx_t pend_port;
    tag_t pend_tag;
    way_vec_t pend_hit, pend_vld_bits;
    word_t pend_word;

    dcache_mem_top dcache_mem_top_i (.*);

    bind dcache_mem_top dcache_mem_chk chk_i (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .rd_hit_oh_i ( rd_hit_oh_o ),
        .rd_ack_i    ( rd_ack_o    ),
        .wr_ack_i    ( wr_ack_o    ),
        .wr_req_i    ( wr_req_i    ),
        .wr_cl_vld_i ( wr_cl_vld_i )
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin : p_timeout
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return (r >> 8) % n;
    endfunction

    function automatic bank_sel_t bank_of(off_t off);
        return bank_sel_t'(off >> $clog2(WORD_BYTES));
    endfunction

    function automatic word_t merge_word(word_t old_w, word_t new_w, word_be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // high priority masks low priority, then first requester from the pointer
    function automatic port_vec_t expect_ack(port_vec_t req, port_vec_t prio, logic en);
        port_vec_t cand;
        port_vec_t res;
        int unsigned p;
        res = '0;
        cand = (|(req & prio)) ? (req & prio) : req;
        for (int i = 0; i < NP; i++) begin
            p = (int'(m_ptr) + i) % NP;
            if (en && cand[p] && res == '0) begin
                res[p] = 1'b1;
            end
        end
        return res;
    endfunction

    task automatic check_value(int cat, string what, logic [63:0] exp, logic [63:0] act);
        assert (act === exp) else begin
            err_cnt[cat]++;
            $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic drive_inputs(int slot);
        int unsigned w;
        rd_req_i = rd_req_i & ~acked;
        for (int p = 0; p < NP; p++) begin
            if (!rd_req_i[p] && rand_below(100) < p_read) begin
                rd_req_i[p] = 1'b1;
                rd_idx_i[p] = idx_t'(rand_below(`DCACHE_NUM_SETS));
                rd_off_i[p] = off_t'(rand_below(1 << `DCACHE_OFF_W));
                rd_tag_only_i[p] = rand_below(100) < p_tag_only;
                rd_prio_i[p] = rand_below(4) == 0;
                want_tag[p] = m_tag[rand_below(NW)][rd_idx_i[p]];
                // flipping the top bit of a way 0 tag matches no way
                if (rand_below(100) < p_miss) begin
                    want_tag[p] = m_tag[0][rd_idx_i[p]] ^ tag_t'(1 << (`DCACHE_TAG_W - 1));
                end
            end
        end
        if (pend_vld) begin
            rd_tag_i[pend_port] = pend_tag;
        end
        if (slot >= 0) begin
            w = slot % NW;
            wr_cl_vld_i = 1'b1;
            wr_cl_idx_i = idx_t'(slot / NW);
            wr_vld_bits_i = '1;
            wr_cl_data_be_i = '1;
        end else begin
            w = rand_below(NW);
            wr_cl_vld_i = rand_below(100) < p_refill;
            wr_cl_idx_i = idx_t'(rand_below(`DCACHE_NUM_SETS));
            wr_vld_bits_i = (rand_below(4) == 0) ? '0 : '1;
            wr_cl_data_be_i = rand_below(2) ? '1 : line_be_t'(next_rand());
        end
        // tag lsb equals the way, so two ways never hold the same tag
        wr_cl_we_i = way_vec_t'(1 << w);
        wr_cl_tag_i = tag_t'((rand_below(1 << (`DCACHE_TAG_W - 1)) << 1) | w);
        for (int i = 0; i < $bits(line_t) / 32; i++) begin
            wr_cl_data_i[32*i +: 32] = next_rand();
        end
        if (wr_done) begin
            wr_req_i = '0;
        end
        if (wr_req_i == '0 && rand_below(100) < p_write) begin
            wr_req_i = way_vec_t'(1 << rand_below(NW));
            wr_idx_i = idx_t'(rand_below(`DCACHE_NUM_SETS));
            wr_off_i = off_t'(rand_below(1 << `DCACHE_OFF_W));
            wr_data_i = {next_rand(), next_rand()};
            wr_data_be_i = word_be_t'(rand_below(256));
        end
    endtask

    task automatic check_cycle();
        port_vec_t exp_ack;
        logic exp_wack;
        logic rd_data;
        int unsigned g;
        int unsigned s;
        bank_sel_t bank;
        if (pend_vld) begin
            check_value(2, "rd_hit_oh_o", pend_hit, rd_hit_oh_o);
            check_value(2, "rd_vld_bits_o", pend_vld_bits, rd_vld_bits_o);
            if (pend_data_chk) begin
                check_value(2, "rd_data_o", pend_word, rd_data_o);
            end
        end else begin
            check_value(2, "rd_hit_oh_o idle", '0, rd_hit_oh_o);
        end
        exp_ack = expect_ack(rd_req_i, rd_prio_i, !wr_cl_vld_i);
        check_value(0, "rd_ack_o", exp_ack, rd_ack_o);
        pend_vld = |exp_ack;
        rd_data = 1'b0;
        g = 0;
        for (int p = 0; p < NP; p++) begin
            if (exp_ack[p]) begin
                g = p;
            end
        end
        if (pend_vld) begin
            s = rd_idx_i[g];
            bank = bank_of(rd_off_i[g]);
            pend_port = port_idx_t'(g);
            pend_tag = want_tag[g];
            pend_data_chk = !rd_tag_only_i[g];
            rd_data = pend_data_chk;
            pend_word = m_data[0][s][bank];
            for (int w = NW - 1; w >= 0; w--) begin
                pend_vld_bits[w] = m_vld[w][s];
                pend_hit[w] = m_vld[w][s] && (m_tag[w][s] == pend_tag);
                if (pend_hit[w]) begin
                    pend_word = m_data[w][s][bank];
                end
            end
            m_ptr = port_idx_t'((g + 1) % NP);
        end
        exp_wack = (|wr_req_i) && !wr_cl_vld_i &&
                   !(rd_data && bank_of(rd_off_i[g]) == bank_of(wr_off_i));
        check_value(1, "wr_ack_o", exp_wack, wr_ack_o);
        // the arrays take these writes at the coming edge
        for (int w = 0; w < NW; w++) begin
            if (wr_cl_vld_i && wr_cl_we_i[w]) begin
                m_tag[w][wr_cl_idx_i] = wr_cl_tag_i;
                m_vld[w][wr_cl_idx_i] = wr_vld_bits_i[w];
                for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
                    m_data[w][wr_cl_idx_i][k] = merge_word(m_data[w][wr_cl_idx_i][k],
                        wr_cl_data_i[k*`DCACHE_WORD_W +: `DCACHE_WORD_W],
                        wr_cl_data_be_i[k*WORD_BYTES +: WORD_BYTES]);
                end
            end
            if (exp_wack && wr_req_i[w]) begin
                m_data[w][wr_idx_i][bank_of(wr_off_i)] = merge_word(
                    m_data[w][wr_idx_i][bank_of(wr_off_i)], wr_data_i, wr_data_be_i);
            end
        end
        acked = rd_ack_o;
        wr_done = wr_ack_o;
    endtask

    task automatic run_cycle(int slot);
        @(posedge clk_i);
        #2;
        drive_inputs(slot);
        @(negedge clk_i);
        check_cycle();
    endtask

    task automatic run_phase(string name, int unsigned rd, int unsigned cl, int unsigned wr,
                             int unsigned tonly, int unsigned miss);
        test_name = name;
        p_read = rd;
        p_refill = cl;
        p_write = wr;
        p_tag_only = tonly;
        p_miss = miss;
        repeat (PHASE_CYCLES) run_cycle(-1);
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin : p_main
        clk_i = 1'b0;
        rst_ni = 1'b0;
        {rd_req_i, rd_tag_only_i, rd_prio_i, rd_idx_i, rd_off_i, rd_tag_i} = '0;
        {wr_cl_vld_i, wr_cl_we_i, wr_cl_tag_i, wr_cl_idx_i, wr_cl_data_i} = '0;
        {wr_cl_data_be_i, wr_vld_bits_i} = '0;
        {wr_req_i, wr_idx_i, wr_off_i, wr_data_i, wr_data_be_i} = '0;
        lcg_state = 32'h52634c59;
        m_ptr = '0;
        {acked, wr_done, pend_vld, pend_data_chk} = '0;
        err_cnt = '{0, 0, 0};
        repeat (3) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // fill every set of every way so later lookups see known contents
        test_name = "init";
        {p_read, p_refill, p_write, p_tag_only, p_miss} = '0;
        for (int i = 0; i < INIT_CYCLES; i++) begin
            run_cycle(i);
        end
        run_phase("refill_read", 60, 15, 0, 0, 25);
        run_phase("arbitration", 90, 20, 0, 20, 20);
        run_phase("word_write", 50, 5, 70, 0, 10);
        run_phase("tag_only", 70, 10, 50, 70, 30);

        $display("errors: arbitration %0d, write ack %0d, lookup %0d, assertion %0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], dcache_mem_top_i.chk_i.fail_cnt);
        if (err_cnt[0] + err_cnt[1] + err_cnt[2] + dcache_mem_top_i.chk_i.fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: dv/dcache_mem_chk.sv
////////////////////
// concurrent assertions bound to the cache memory top level
////////////////////

`timescale 1ns/1ps

module dcache_mem_chk (
    input logic                  clk_i,
    input logic                  rst_ni,
    input dcache_pkg::way_vec_t  rd_hit_oh_i,
    input dcache_pkg::port_vec_t rd_ack_i,
    input logic                  wr_ack_i,
    input dcache_pkg::way_vec_t  wr_req_i,
    input logic                  wr_cl_vld_i
);

    int unsigned fail_cnt = 0;

    // at most one way may hit
    a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(rd_hit_oh_i))
        else begin
            fail_cnt++;
            $error("hit vector has more than one way set");
        end

    a_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(rd_ack_i))
        else begin
            fail_cnt++;
            $error("more than one read port acked");
        end

    // a word write goes to a single way
    a_wr_way: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_ack_i |-> $onehot0(wr_req_i))
        else begin
            fail_cnt++;
            $error("word write acked with several ways");
        end

    // refills stall the read ports
    a_refill_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_cl_vld_i |-> (rd_ack_i == '0))
        else begin
            fail_cnt++;
            $error("read acked during a refill");
        end

endmodule

// File: design/dcache_mem_top.sv
////////////////////
// data cache memories with arbiter, bank control, banks, tags and hit select
////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_mem_top (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    // read ports
    input  dcache_pkg::port_vec_t                     rd_req_i,
    input  dcache_pkg::idx_t [`DCACHE_NUM_PORTS-1:0]  rd_idx_i,
    input  dcache_pkg::off_t [`DCACHE_NUM_PORTS-1:0]  rd_off_i,
    input  dcache_pkg::port_vec_t                     rd_tag_only_i,
    input  dcache_pkg::port_vec_t                     rd_prio_i,
    input  dcache_pkg::tag_t [`DCACHE_NUM_PORTS-1:0]  rd_tag_i,
    output dcache_pkg::port_vec_t                     rd_ack_o,
    output dcache_pkg::way_vec_t                      rd_vld_bits_o,
    output dcache_pkg::way_vec_t                      rd_hit_oh_o,
    output dcache_pkg::word_t                         rd_data_o,
    // refill port
    input  logic                                      wr_cl_vld_i,
    input  dcache_pkg::way_vec_t                      wr_cl_we_i,
    input  dcache_pkg::tag_t                          wr_cl_tag_i,
    input  dcache_pkg::idx_t                          wr_cl_idx_i,
    input  dcache_pkg::line_t                         wr_cl_data_i,
    input  dcache_pkg::line_be_t                      wr_cl_data_be_i,
    input  dcache_pkg::way_vec_t                      wr_vld_bits_i,
    // word-write port
    input  dcache_pkg::way_vec_t                      wr_req_i,
    output logic                                      wr_ack_o,
    input  dcache_pkg::idx_t                          wr_idx_i,
    input  dcache_pkg::off_t                          wr_off_i,
    input  dcache_pkg::word_t                         wr_data_i,
    input  dcache_pkg::word_be_t                      wr_data_be_i
);

    logic                  rd_gnt;
    dcache_pkg::port_idx_t rd_gnt_idx;
    logic                  cmp_en;
    dcache_pkg::bank_sel_t rd_bank_q;
    dcache_pkg::port_idx_t rd_port_q;
    dcache_pkg::way_vec_t  tag_req;
    logic                  tag_we;
    dcache_pkg::idx_t      tag_idx;

    dcache_pkg::tag_t [`DCACHE_WAYS-1:0] tag_rdata;

    dcache_pkg::bank_op_e [`DCACHE_NUM_BANKS-1:0]                   bank_op;
    dcache_pkg::idx_t [`DCACHE_NUM_BANKS-1:0]                       bank_idx;
    dcache_pkg::word_be_t [`DCACHE_NUM_BANKS-1:0][`DCACHE_WAYS-1:0] bank_be;
    dcache_pkg::word_t [`DCACHE_NUM_BANKS-1:0][`DCACHE_WAYS-1:0]    bank_wdata;
    dcache_pkg::word_t [`DCACHE_NUM_BANKS-1:0][`DCACHE_WAYS-1:0]    bank_rdata;

    // refills stall the read ports
    dcache_rr_arbiter i_rr_arbiter (
        .clk_i     ( clk_i        ),
        .rst_ni    ( rst_ni       ),
        .en_i      ( ~wr_cl_vld_i ),
        .req_i     ( rd_req_i     ),
        .prio_i    ( rd_prio_i    ),
        .ack_o     ( rd_ack_o     ),
        .gnt_o     ( rd_gnt       ),
        .gnt_idx_o ( rd_gnt_idx   )
    );

    dcache_bank_ctrl i_bank_ctrl (
        .clk_i         ( clk_i           ),
        .rst_ni        ( rst_ni          ),
        .wr_cl_vld_i   ( wr_cl_vld_i     ),
        .wr_cl_we_i    ( wr_cl_we_i      ),
        .wr_cl_idx_i   ( wr_cl_idx_i     ),
        .wr_cl_be_i    ( wr_cl_data_be_i ),
        .rd_gnt_i      ( rd_gnt          ),
        .rd_gnt_idx_i  ( rd_gnt_idx      ),
        .rd_idx_i      ( rd_idx_i        ),
        .rd_off_i      ( rd_off_i        ),
        .rd_tag_only_i ( rd_tag_only_i   ),
        .wr_req_i      ( wr_req_i        ),
        .wr_idx_i      ( wr_idx_i        ),
        .wr_off_i      ( wr_off_i        ),
        .wr_be_i       ( wr_data_be_i    ),
        .wr_ack_o      ( wr_ack_o        ),
        .bank_op_o     ( bank_op         ),
        .bank_idx_o    ( bank_idx        ),
        .bank_be_o     ( bank_be         ),
        .tag_req_o     ( tag_req         ),
        .tag_we_o      ( tag_we          ),
        .tag_idx_o     ( tag_idx         ),
        .cmp_en_o      ( cmp_en          ),
        .rd_bank_q_o   ( rd_bank_q       ),
        .rd_port_q_o   ( rd_port_q       )
    );

    ////////////////////
    // data banks
    ////////////////////

    for (genvar k = 0; k < `DCACHE_NUM_BANKS; k++) begin : g_bank
        for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
            // refill slice of the line or the single write word
            assign bank_wdata[k][w] = wr_cl_vld_i ?
                wr_cl_data_i[k*`DCACHE_WORD_W +: `DCACHE_WORD_W] : wr_data_i;
        end

        dcache_data_bank i_data_bank (
            .clk_i   ( clk_i         ),
            .op_i    ( bank_op[k]    ),
            .idx_i   ( bank_idx[k]   ),
            .be_i    ( bank_be[k]    ),
            .wdata_i ( bank_wdata[k] ),
            .rdata_o ( bank_rdata[k] )
        );
    end

    dcache_tag_array i_tag_array (
        .clk_i  ( clk_i         ),
        .req_i  ( tag_req       ),
        .we_i   ( tag_we        ),
        .idx_i  ( tag_idx       ),
        .wtag_i ( wr_cl_tag_i   ),
        .wvld_i ( wr_vld_bits_i ),
        .tag_o  ( tag_rdata     ),
        .vld_o  ( rd_vld_bits_o )
    );

    // tag arrives one cycle after the ack, from the acked port
    dcache_hit_select i_hit_select (
        .cmp_en_i     ( cmp_en              ),
        .rd_tag_i     ( rd_tag_i[rd_port_q] ),
        .tag_i        ( tag_rdata           ),
        .vld_i        ( rd_vld_bits_o       ),
        .bank_sel_i   ( rd_bank_q           ),
        .bank_rdata_i ( bank_rdata          ),
        .hit_oh_o     ( rd_hit_oh_o         ),
        .rdata_o      ( rd_data_o           )
    );

endmodule

// File: design/dcache_hit_select.sv
////////////////////
// tag compare, one-hot hit vector and read word mux
////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_hit_select (
    input  logic                                  cmp_en_i,
    input  dcache_pkg::tag_t                      rd_tag_i,
    input  dcache_pkg::tag_t [`DCACHE_WAYS-1:0]   tag_i,
    input  dcache_pkg::way_vec_t                  vld_i,
    input  dcache_pkg::bank_sel_t                 bank_sel_i,
    input  dcache_pkg::word_t [`DCACHE_NUM_BANKS-1:0][`DCACHE_WAYS-1:0] bank_rdata_i,
    output dcache_pkg::way_vec_t                  hit_oh_o,
    output dcache_pkg::word_t                     rdata_o
);
    import dcache_pkg::*;

    localparam int unsigned WAY_IDX_W = (`DCACHE_WAYS > 1) ? $clog2(`DCACHE_WAYS) : 1;

    word_t [`DCACHE_WAYS-1:0] way_word;
    logic [WAY_IDX_W-1:0]     hit_idx;

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        // only a lookup from the previous cycle may hit
        assign hit_oh_o[w] = cmp_en_i & vld_i[w] & (tag_i[w] == rd_tag_i);
        assign way_word[w] = bank_rdata_i[bank_sel_i][w];
    end

    // lowest hitting way wins and way 0 is taken on a miss
    always_comb begin : p_hit_idx
        hit_idx = '0;
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (hit_oh_o[w]) begin
                hit_idx = WAY_IDX_W'(w);
            end
        end
    end

    assign rdata_o = way_word[hit_idx];

endmodule

// File: design/dcache_tag_array.sv
////////////////////
// per-way tag and valid SRAMs
////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_tag_array (
    input  logic                                  clk_i,
    input  dcache_pkg::way_vec_t                  req_i,
    input  logic                                  we_i,
    input  dcache_pkg::idx_t                      idx_i,
    input  dcache_pkg::tag_t                      wtag_i,
    input  dcache_pkg::way_vec_t                  wvld_i,
    output dcache_pkg::tag_t [`DCACHE_WAYS-1:0]   tag_o,
    output dcache_pkg::way_vec_t                  vld_o
);
    import dcache_pkg::*;

    localparam int unsigned ENTRY_W = $bits(tag_t) + 1;

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        // valid bit on top of the tag
        logic [ENTRY_W-1:0] mem [`DCACHE_NUM_SETS];
        logic [ENTRY_W-1:0] rdata_q;

        always_ff @(posedge clk_i) begin : p_sram
            if (req_i[w]) begin
                if (we_i) begin
                    mem[idx_i] <= {wvld_i[w], wtag_i};
                end else begin
                    rdata_q <= mem[idx_i];
                end
            end
        end

        // split the entry back into its fields
        assign tag_o[w] = rdata_q[ENTRY_W-2:0];
        assign vld_o[w] = rdata_q[ENTRY_W-1];
    end

endmodule

// File: design/dcache_data_bank.sv
////////////////////
// one data SRAM bank, one word per way, byte enables
////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_data_bank (
    input  logic                                      clk_i,
    input  dcache_pkg::bank_op_e                      op_i,
    input  dcache_pkg::idx_t                          idx_i,
    input  dcache_pkg::word_be_t [`DCACHE_WAYS-1:0]   be_i,
    input  dcache_pkg::word_t [`DCACHE_WAYS-1:0]      wdata_i,
    output dcache_pkg::word_t [`DCACHE_WAYS-1:0]      rdata_o
);
    import dcache_pkg::*;

    localparam int unsigned WORD_BYTES = `DCACHE_WORD_W / 8;

    // all ways of one word offset sit side by side in an entry
    word_t [`DCACHE_WAYS-1:0] mem [`DCACHE_NUM_SETS];

    always_ff @(posedge clk_i) begin : p_sram
        if (op_i == BANK_WRITE) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (be_i[w][b]) begin
                        mem[idx_i][w][8*b +: 8] <= wdata_i[w][8*b +: 8];
                    end
                end
            end
        end else if (op_i == BANK_READ) begin
            // read data holds until the next read of this bank
            rdata_o <= mem[idx_i];
        end
    end

endmodule

// File: design/dcache_bank_ctrl.sv
////////////////////
// bank and tag steering, word-write collision check and ack
// plus the registered lookup context
////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_bank_ctrl (
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic                                           wr_cl_vld_i,
    input  dcache_pkg::way_vec_t                           wr_cl_we_i,
    input  dcache_pkg::idx_t                               wr_cl_idx_i,
    input  dcache_pkg::line_be_t                           wr_cl_be_i,
    input  logic                                           rd_gnt_i,
    input  dcache_pkg::port_idx_t                          rd_gnt_idx_i,
    input  dcache_pkg::idx_t [`DCACHE_NUM_PORTS-1:0]       rd_idx_i,
    input  dcache_pkg::off_t [`DCACHE_NUM_PORTS-1:0]       rd_off_i,
    input  dcache_pkg::port_vec_t                          rd_tag_only_i,
    input  dcache_pkg::way_vec_t                           wr_req_i,
    input  dcache_pkg::idx_t                               wr_idx_i,
    input  dcache_pkg::off_t                               wr_off_i,
    input  dcache_pkg::word_be_t                           wr_be_i,
    output logic                                           wr_ack_o,
    output dcache_pkg::bank_op_e [`DCACHE_NUM_BANKS-1:0]   bank_op_o,
    output dcache_pkg::idx_t [`DCACHE_NUM_BANKS-1:0]       bank_idx_o,
    output dcache_pkg::word_be_t [`DCACHE_NUM_BANKS-1:0][`DCACHE_WAYS-1:0] bank_be_o,
    output dcache_pkg::way_vec_t                           tag_req_o,
    output logic                                           tag_we_o,
    output dcache_pkg::idx_t                               tag_idx_o,
    output logic                                           cmp_en_o,
    output dcache_pkg::bank_sel_t                          rd_bank_q_o,
    output dcache_pkg::port_idx_t                          rd_port_q_o
);
    import dcache_pkg::*;

    localparam int unsigned WORD_BYTES = `DCACHE_WORD_W / 8;
    localparam int unsigned BYTE_OFF_W = $clog2(WORD_BYTES);

    bank_sel_t rd_bank;
    bank_sel_t wr_bank;
    logic      rd_data;
    logic      cl_write;
    logic      collision;

    // bank number is the word offset above the byte offset
    assign rd_bank = rd_off_i[rd_gnt_idx_i][`DCACHE_OFF_W-1:BYTE_OFF_W];
    assign wr_bank = wr_off_i[`DCACHE_OFF_W-1:BYTE_OFF_W];

    // tag-only reads leave the data banks alone
    assign rd_data   = rd_gnt_i & ~rd_tag_only_i[rd_gnt_idx_i];
    assign cl_write  = wr_cl_vld_i & (|wr_cl_we_i);
    assign collision = rd_data & (rd_bank == wr_bank);
    assign wr_ack_o  = (|wr_req_i) & ~wr_cl_vld_i & ~collision;

    ////////////////////
    // data bank steering
    ////////////////////

    always_comb begin : p_banks
        for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
            bank_op_o[k]  = BANK_IDLE;
            bank_idx_o[k] = wr_idx_i;
            bank_be_o[k]  = '0;
            if (cl_write) begin
                // refill writes its slice of the line into every bank
                bank_op_o[k]  = BANK_WRITE;
                bank_idx_o[k] = wr_cl_idx_i;
                for (int w = 0; w < `DCACHE_WAYS; w++) begin
                    if (wr_cl_we_i[w]) begin
                        bank_be_o[k][w] = wr_cl_be_i[k*WORD_BYTES +: WORD_BYTES];
                    end
                end
            end else if (rd_data && (rd_bank == bank_sel_t'(k))) begin
                bank_op_o[k]  = BANK_READ;
                bank_idx_o[k] = rd_idx_i[rd_gnt_idx_i];
            end else if (wr_ack_o && (wr_bank == bank_sel_t'(k))) begin
                bank_op_o[k] = BANK_WRITE;
                for (int w = 0; w < `DCACHE_WAYS; w++) begin
                    bank_be_o[k][w] = wr_req_i[w] ? wr_be_i : '0;
                end
            end
        end
    end

    ////////////////////
    // tag array steering
    ////////////////////

    assign tag_we_o  = wr_cl_vld_i;
    assign tag_req_o = wr_cl_vld_i ? wr_cl_we_i : {`DCACHE_WAYS{rd_gnt_i}};
    assign tag_idx_o = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[rd_gnt_idx_i];

    // lookup context for the compare one cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_lookup
        if (!rst_ni) begin
            cmp_en_o    <= 1'b0;
            rd_bank_q_o <= '0;
            rd_port_q_o <= '0;
        end else begin
            cmp_en_o <= rd_gnt_i;
            if (rd_gnt_i) begin
                rd_bank_q_o <= rd_bank;
                rd_port_q_o <= rd_gnt_idx_i;
            end
        end
    end

endmodule

// File: design/dcache_rr_arbiter.sv
////////////////////
// read-port arbiter with priority masking and round-robin pointer
////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_rr_arbiter (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  en_i,
    input  dcache_pkg::port_vec_t req_i,
    input  dcache_pkg::port_vec_t prio_i,
    output dcache_pkg::port_vec_t ack_o,
    output logic                  gnt_o,
    output dcache_pkg::port_idx_t gnt_idx_o
);
    import dcache_pkg::*;

    port_vec_t req_prio;
    port_vec_t req_masked;
    port_idx_t ptr_q;
    port_idx_t ptr_d;

    // high priority requests shut out all low priority ones
    assign req_prio   = req_i & prio_i;
    assign req_masked = (|req_prio) ? req_prio : req_i;

    // first competing port at or after the pointer in cyclic order
    always_comb begin : p_pick
        int unsigned cand;
        gnt_o     = 1'b0;
        gnt_idx_o = '0;
        for (int unsigned i = 0; i < `DCACHE_NUM_PORTS; i++) begin
            cand = (int'(ptr_q) + i) % `DCACHE_NUM_PORTS;
            if (!gnt_o && en_i && req_masked[cand]) begin
                gnt_o     = 1'b1;
                gnt_idx_o = port_idx_t'(cand);
            end
        end
    end

    always_comb begin : p_ack
        ack_o = '0;
        if (gnt_o) begin
            ack_o[gnt_idx_o] = 1'b1;
        end
    end

    // pointer moves past the winner
    assign ptr_d = (gnt_idx_o == port_idx_t'(`DCACHE_NUM_PORTS - 1)) ?
                   '0 : gnt_idx_o + 1'b1;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (gnt_o) begin
            ptr_q <= ptr_d;
        end
    end

endmodule

// File: design/dcache_pkg.sv
////////////////////
// field types and bank operation codes of the data cache memories
////////////////////

package dcache_pkg;

    `include "dcache_consts.svh"

    // address fields
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_IDX_W-1:0] idx_t;
    typedef logic [`DCACHE_OFF_W-1:0] off_t;

    // word offset within a line, which doubles as the bank number
    typedef logic [$clog2(`DCACHE_NUM_BANKS)-1:0] bank_sel_t;

    // per way and per port vectors
    typedef logic [`DCACHE_WAYS-1:0]               way_vec_t;
    typedef logic [`DCACHE_NUM_PORTS-1:0]          port_vec_t;
    typedef logic [$clog2(`DCACHE_NUM_PORTS)-1:0]  port_idx_t;

    // data words and lines
    typedef logic [`DCACHE_WORD_W-1:0]   word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0] word_be_t;

    typedef logic [`DCACHE_NUM_BANKS*`DCACHE_WORD_W-1:0]   line_t;
    typedef logic [`DCACHE_NUM_BANKS*`DCACHE_WORD_W/8-1:0] line_be_t;

    // what a data bank does in a cycle
    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_READ,
        BANK_WRITE
    } bank_op_e;

endpackage

// File: include/dcache_consts.svh
////////////////////
// sizing constants for the data cache memories
// ports, ways, banks, field widths and set count
////////////////////

`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// read ports into the arrays
`define DCACHE_NUM_PORTS 3

// associativity
`define DCACHE_WAYS 2

// 64-bit words per line with one bank each
`define DCACHE_NUM_BANKS 4

// address fields
`define DCACHE_TAG_W 12
`define DCACHE_IDX_W 6
`define DCACHE_OFF_W 5

`define DCACHE_NUM_SETS 64
`define DCACHE_WORD_W 64

`endif
